// File: verilog/hart_pkg.sv
package hart_pkg;

  localparam int unsigned XLEN       = 32;  // data and address width
  localparam int unsigned REG_ADDR_W = 5;   // register index width

  localparam logic [XLEN-1:0] RESET_ADDR  = 32'h0000_0000;  // first fetch address
  localparam logic [31:0]     NOP_INST    = 32'h0000_0013;  // addi x0, x0, 0 for bubbles
  localparam logic [31:0]     EBREAK_INST = 32'h0010_0073;  // ends the program

  // major opcodes of the supported rv32i subset
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU, WB_MEM, WB_PC4, WB_IMM  // writeback source, pc4 is the link value of jumps
  } wb_sel_e;

  // control word built in decode, travels with the instruction to writeback
  typedef struct packed {
    alu_op_e alu_op;
    wb_sel_e wb_sel;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    jal;
    logic    jalr;
    logic    use_imm;  // second alu operand is the immediate
    logic    halt;
  } ctrl_t;

  typedef struct packed {
    logic            valid;
    logic [31:0]     inst;
    logic [XLEN-1:0] pc;
    ctrl_t           ctrl;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
  } id_ex_t;

  typedef struct packed {
    logic            valid;
    logic [31:0]     inst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;     // resolved in execute, reported at retire
    ctrl_t           ctrl;
    logic [XLEN-1:0] alu_result;  // also the dmem address of loads and stores
    logic [XLEN-1:0] store_data;
    logic [XLEN-1:0] imm;
  } ex_mem_t;

  typedef ex_mem_t mem_wb_t;  // writeback needs the same fields as memory

  typedef struct packed {
    logic                  valid;
    logic [31:0]           inst;
    logic                  halt;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       next_pc;
    logic [REG_ADDR_W-1:0] rd_waddr;  // zero when nothing is written
    logic [XLEN-1:0]       rd_wdata;
  } retire_t;

endpackage

// File: verilog/hart_decode.sv
`timescale 1ns/1ps

module hart_decode (
  input  logic [hart_pkg::XLEN-1:0] i_inst,
  output hart_pkg::ctrl_t           o_ctrl,
  output logic [hart_pkg::XLEN-1:0] o_imm,
  output logic                      o_uses_rs1,
  output logic                      o_uses_rs2
);

  logic [6:0]                opcode;
  logic [2:0]                funct3;
  logic                      funct7_b5;  // picks sub over add and sra over srl
  hart_pkg::alu_op_e         alu_sel;    // alu op for the register and immediate forms
  logic [hart_pkg::XLEN-1:0] imm_i;
  logic [hart_pkg::XLEN-1:0] imm_s;
  logic [hart_pkg::XLEN-1:0] imm_b;
  logic [hart_pkg::XLEN-1:0] imm_u;
  logic [hart_pkg::XLEN-1:0] imm_j;

  assign opcode    = i_inst[6:0];
  assign funct3    = i_inst[14:12];
  assign funct7_b5 = i_inst[30];

  // all immediates are sign extended from bit 31
  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'h000};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (funct3)
      3'b000:  alu_sel = (opcode == hart_pkg::OP_REG && funct7_b5) ? hart_pkg::ALU_SUB
                                                                    : hart_pkg::ALU_ADD;
      3'b001:  alu_sel = hart_pkg::ALU_SLL;
      3'b010:  alu_sel = hart_pkg::ALU_SLT;
      3'b011:  alu_sel = hart_pkg::ALU_SLTU;
      3'b100:  alu_sel = hart_pkg::ALU_XOR;
      3'b101:  alu_sel = funct7_b5 ? hart_pkg::ALU_SRA : hart_pkg::ALU_SRL;  // srai has bit 30 too
      3'b110:  alu_sel = hart_pkg::ALU_OR;
      default: alu_sel = hart_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    o_ctrl     = '0;  // anything unknown falls through as a no-op with no register write
    o_uses_rs1 = 1'b0;
    o_uses_rs2 = 1'b0;
    o_imm      = imm_i;
    case (opcode)
      hart_pkg::OP_LUI: begin
        o_ctrl.wb_sel    = hart_pkg::WB_IMM;  // upper immediate goes straight to rd
        o_ctrl.reg_write = 1'b1;
        o_imm            = imm_u;
      end
      hart_pkg::OP_JAL: begin
        o_ctrl.wb_sel    = hart_pkg::WB_PC4;
        o_ctrl.reg_write = 1'b1;
        o_ctrl.jal       = 1'b1;
        o_imm            = imm_j;
      end
      hart_pkg::OP_JALR: begin
        o_ctrl.wb_sel    = hart_pkg::WB_PC4;
        o_ctrl.reg_write = 1'b1;
        o_ctrl.jalr      = 1'b1;
        o_uses_rs1       = 1'b1;
      end
      hart_pkg::OP_BRANCH: begin
        if (funct3 inside {3'b000, 3'b001, 3'b100, 3'b101}) begin  // beq bne blt bge only
          o_ctrl.branch = 1'b1;
          o_uses_rs1    = 1'b1;
          o_uses_rs2    = 1'b1;
        end
        o_imm = imm_b;
      end
      hart_pkg::OP_LOAD: begin
        if (funct3 == 3'b010) begin  // lw, the address comes from the alu add
          o_ctrl.wb_sel    = hart_pkg::WB_MEM;
          o_ctrl.reg_write = 1'b1;
          o_ctrl.mem_read  = 1'b1;
          o_ctrl.use_imm   = 1'b1;
          o_uses_rs1       = 1'b1;
        end
      end
      hart_pkg::OP_STORE: begin
        if (funct3 == 3'b010) begin  // sw
          o_ctrl.mem_write = 1'b1;
          o_ctrl.use_imm   = 1'b1;
          o_uses_rs1       = 1'b1;
          o_uses_rs2       = 1'b1;
        end
        o_imm = imm_s;
      end
      hart_pkg::OP_IMM: begin
        o_ctrl.alu_op    = alu_sel;
        o_ctrl.reg_write = 1'b1;
        o_ctrl.use_imm   = 1'b1;
        o_uses_rs1       = 1'b1;
      end
      hart_pkg::OP_REG: begin
        o_ctrl.alu_op    = alu_sel;
        o_ctrl.reg_write = 1'b1;
        o_uses_rs1       = 1'b1;
        o_uses_rs2       = 1'b1;
      end
      default: ;
    endcase
    if (i_inst == hart_pkg::EBREAK_INST)
      o_ctrl.halt = 1'b1;  // ebreak is only flagged, it writes nothing
  end

endmodule

// File: verilog/hart_regfile.sv
`timescale 1ns/1ps

module hart_regfile (
  input  logic                            i_clk,
  input  logic                            i_rst,
  input  logic [hart_pkg::REG_ADDR_W-1:0] i_rs1_raddr,
  input  logic [hart_pkg::REG_ADDR_W-1:0] i_rs2_raddr,
  output logic [hart_pkg::XLEN-1:0]       o_rs1_rdata,
  output logic [hart_pkg::XLEN-1:0]       o_rs2_rdata,
  input  logic [hart_pkg::REG_ADDR_W-1:0] i_rd_waddr,
  input  logic                            i_rd_wen,
  input  logic [hart_pkg::XLEN-1:0]       i_rd_wdata
);

  // x0 has no storage, index 0 is never written or read
  logic [hart_pkg::XLEN-1:0] regs [1:(2**hart_pkg::REG_ADDR_W)-1];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 2**hart_pkg::REG_ADDR_W; i++)
        regs[i] <= '0;
    end else if (i_rd_wen && i_rd_waddr != '0) begin
      regs[i_rd_waddr] <= i_rd_wdata;
    end
  end

  // a read of the register being written sees the new value, so writeback
  // never has to be checked for hazards in decode
  assign o_rs1_rdata = (i_rs1_raddr == '0) ? '0 :
                       (i_rd_wen && i_rd_waddr == i_rs1_raddr) ? i_rd_wdata : regs[i_rs1_raddr];
  assign o_rs2_rdata = (i_rs2_raddr == '0) ? '0 :
                       (i_rd_wen && i_rd_waddr == i_rs2_raddr) ? i_rd_wdata : regs[i_rs2_raddr];

endmodule

// File: verilog/hart_execute.sv
`timescale 1ns/1ps

module hart_execute (
  input  hart_pkg::id_ex_t          i_id_ex,
  output logic [hart_pkg::XLEN-1:0] o_alu_result,
  output logic                      o_redirect,
  output logic [hart_pkg::XLEN-1:0] o_target
);

  logic [hart_pkg::XLEN-1:0] op_a;
  logic [hart_pkg::XLEN-1:0] op_b;
  logic [hart_pkg::XLEN-1:0] jalr_sum;  // rs1 + imm before bit 0 is dropped
  logic                      rs_eq;
  logic                      rs_lt;     // signed compare for blt and bge
  logic                      cond;
  logic                      taken;

  assign op_a = i_id_ex.rs1_data;
  assign op_b = i_id_ex.ctrl.use_imm ? i_id_ex.imm : i_id_ex.rs2_data;

  always_comb begin
    case (i_id_ex.ctrl.alu_op)
      hart_pkg::ALU_SUB:  o_alu_result = op_a - op_b;
      hart_pkg::ALU_AND:  o_alu_result = op_a & op_b;
      hart_pkg::ALU_OR:   o_alu_result = op_a | op_b;
      hart_pkg::ALU_XOR:  o_alu_result = op_a ^ op_b;
      hart_pkg::ALU_SLT:  o_alu_result = {{(hart_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      hart_pkg::ALU_SLTU: o_alu_result = {{(hart_pkg::XLEN-1){1'b0}}, op_a < op_b};
      hart_pkg::ALU_SLL:  o_alu_result = op_a << op_b[4:0];  // shift amount is the low five bits
      hart_pkg::ALU_SRL:  o_alu_result = op_a >> op_b[4:0];
      hart_pkg::ALU_SRA:  o_alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
      default:            o_alu_result = op_a + op_b;  // add, also load and store addresses
    endcase
  end

  // branches always compare the two registers, never the immediate
  assign rs_eq = i_id_ex.rs1_data == i_id_ex.rs2_data;
  assign rs_lt = $signed(i_id_ex.rs1_data) < $signed(i_id_ex.rs2_data);

  always_comb begin
    case (i_id_ex.inst[14:12])
      3'b000:  cond = rs_eq;   // beq
      3'b001:  cond = !rs_eq;  // bne
      3'b100:  cond = rs_lt;   // blt
      3'b101:  cond = !rs_lt;  // bge
      default: cond = 1'b0;
    endcase
  end

  assign taken      = (i_id_ex.ctrl.branch && cond) || i_id_ex.ctrl.jal || i_id_ex.ctrl.jalr;
  assign o_redirect = i_id_ex.valid && taken;  // bubbles never redirect

  assign jalr_sum = i_id_ex.rs1_data + i_id_ex.imm;
  assign o_target = i_id_ex.ctrl.jalr ? {jalr_sum[hart_pkg::XLEN-1:1], 1'b0}
                                      : i_id_ex.pc + i_id_ex.imm;

endmodule

// File: verilog/hart_hazard.sv
`timescale 1ns/1ps

module hart_hazard (
  input  logic [hart_pkg::REG_ADDR_W-1:0] i_rs1,
  input  logic [hart_pkg::REG_ADDR_W-1:0] i_rs2,
  input  logic                            i_uses_rs1,
  input  logic                            i_uses_rs2,
  input  logic                            i_if_id_valid,
  input  logic [hart_pkg::REG_ADDR_W-1:0] i_ex_rd,
  input  logic                            i_ex_reg_write,
  input  logic [hart_pkg::REG_ADDR_W-1:0] i_mem_rd,
  input  logic                            i_mem_reg_write,
  output logic                            o_stall
);

  logic rs1_hit;  // rs1 still waits on an older result
  logic rs2_hit;

  // writeback is left out because the register file passes same-cycle writes through
  assign rs1_hit = i_uses_rs1 && (i_rs1 != '0) &&
                   ((i_ex_reg_write && i_rs1 == i_ex_rd) || (i_mem_reg_write && i_rs1 == i_mem_rd));
  assign rs2_hit = i_uses_rs2 && (i_rs2 != '0) &&
                   ((i_ex_reg_write && i_rs2 == i_ex_rd) || (i_mem_reg_write && i_rs2 == i_mem_rd));

  assign o_stall = i_if_id_valid && (rs1_hit || rs2_hit);

endmodule

// File: verilog/hart.sv
`timescale 1ns/1ps

module hart (
  input  logic                        i_clk,
  input  logic                        i_rst,
  output logic [hart_pkg::XLEN-1:0]   o_imem_raddr,
  input  logic [hart_pkg::XLEN-1:0]   i_imem_rdata,
  output logic [hart_pkg::XLEN-1:0]   o_dmem_addr,
  output logic                        o_dmem_ren,
  output logic                        o_dmem_wen,
  output logic [hart_pkg::XLEN-1:0]   o_dmem_wdata,
  output logic [hart_pkg::XLEN/8-1:0] o_dmem_mask,
  input  logic [hart_pkg::XLEN-1:0]   i_dmem_rdata,
  output hart_pkg::retire_t           o_retire
);

  logic [hart_pkg::XLEN-1:0]       pc_q;         // fetch address
  logic [hart_pkg::XLEN-1:0]       if_id_pc;     // address of the word now on i_imem_rdata
  logic                            if_id_valid;
  logic                            stall;
  logic                            hold;         // stall that survives a redirect
  logic                            id_fire;      // decode hands a real instruction to execute
  logic                            redirect;
  logic [hart_pkg::XLEN-1:0]       target;
  logic [hart_pkg::XLEN-1:0]       alu_result;
  hart_pkg::ctrl_t                 dec_ctrl;
  logic [hart_pkg::XLEN-1:0]       dec_imm;
  logic                            dec_uses_rs1;
  logic                            dec_uses_rs2;
  logic [hart_pkg::XLEN-1:0]       rs1_rdata;
  logic [hart_pkg::XLEN-1:0]       rs2_rdata;
  hart_pkg::id_ex_t                id_ex_d;
  hart_pkg::id_ex_t                id_ex_q;
  hart_pkg::ex_mem_t               ex_mem_q;
  hart_pkg::mem_wb_t               mem_wb_q;
  logic [hart_pkg::XLEN-1:0]       wb_data;
  logic                            rd_wen;
  logic [hart_pkg::REG_ADDR_W-1:0] rd_waddr;

  assign hold    = stall && !redirect;  // a squash always beats a stall
  assign id_fire = if_id_valid && !stall && !redirect;

  // imem answers one clock late, so while stalled the decode word is fetched again
  assign o_imem_raddr = hold ? if_id_pc : pc_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q        <= hart_pkg::RESET_ADDR;
      if_id_valid <= 1'b0;
    end else if (redirect) begin
      pc_q        <= target;
      if_id_valid <= 1'b0;  // the word fetched this cycle is on the wrong path
    end else if (!hold) begin
      pc_q        <= pc_q + 32'd4;
      if_id_valid <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!hold)
      if_id_pc <= pc_q;
  end

  hart_decode decode_i (.i_inst(i_imem_rdata), .o_ctrl(dec_ctrl), .o_imm(dec_imm),
                        .o_uses_rs1(dec_uses_rs1), .o_uses_rs2(dec_uses_rs2));

  hart_regfile regfile_i (.i_clk(i_clk), .i_rst(i_rst),
                          .i_rs1_raddr(i_imem_rdata[19:15]), .i_rs2_raddr(i_imem_rdata[24:20]),
                          .o_rs1_rdata(rs1_rdata), .o_rs2_rdata(rs2_rdata),
                          .i_rd_waddr(rd_waddr), .i_rd_wen(rd_wen), .i_rd_wdata(wb_data));

  hart_hazard hazard_i (.i_rs1(i_imem_rdata[19:15]), .i_rs2(i_imem_rdata[24:20]),
                        .i_uses_rs1(dec_uses_rs1), .i_uses_rs2(dec_uses_rs2),
                        .i_if_id_valid(if_id_valid),
                        .i_ex_rd(id_ex_q.inst[11:7]),
                        .i_ex_reg_write(id_ex_q.valid && id_ex_q.ctrl.reg_write),
                        .i_mem_rd(ex_mem_q.inst[11:7]),
                        .i_mem_reg_write(ex_mem_q.valid && ex_mem_q.ctrl.reg_write),
                        .o_stall(stall));

  always_comb begin
    id_ex_d.valid    = id_fire;
    id_ex_d.inst     = id_fire ? i_imem_rdata : hart_pkg::NOP_INST;  // bubble is a plain nop
    id_ex_d.pc       = if_id_pc;
    id_ex_d.ctrl     = id_fire ? dec_ctrl : '0;
    id_ex_d.rs1_data = rs1_rdata;
    id_ex_d.rs2_data = rs2_rdata;
    id_ex_d.imm      = dec_imm;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      id_ex_q.valid <= 1'b0;
      id_ex_q.ctrl  <= '0;
    end else begin
      id_ex_q <= id_ex_d;
    end
  end

  hart_execute execute_i (.i_id_ex(id_ex_q), .o_alu_result(alu_result),
                          .o_redirect(redirect), .o_target(target));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ex_mem_q.valid <= 1'b0;
      ex_mem_q.ctrl  <= '0;
    end else begin
      ex_mem_q.valid      <= id_ex_q.valid;
      ex_mem_q.inst       <= id_ex_q.inst;
      ex_mem_q.pc         <= id_ex_q.pc;
      ex_mem_q.next_pc    <= redirect ? target : id_ex_q.pc + 32'd4;
      ex_mem_q.ctrl       <= id_ex_q.ctrl;
      ex_mem_q.alu_result <= alu_result;
      ex_mem_q.store_data <= id_ex_q.rs2_data;
      ex_mem_q.imm        <= id_ex_q.imm;
    end
  end

  // memory stage drives the dmem port, load data comes back in writeback
  assign o_dmem_addr  = ex_mem_q.alu_result;
  assign o_dmem_ren   = ex_mem_q.valid && ex_mem_q.ctrl.mem_read;
  assign o_dmem_wen   = ex_mem_q.valid && ex_mem_q.ctrl.mem_write;
  assign o_dmem_wdata = ex_mem_q.store_data;
  assign o_dmem_mask  = '1;  // word accesses only

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mem_wb_q.valid <= 1'b0;
      mem_wb_q.ctrl  <= '0;
    end else begin
      mem_wb_q <= ex_mem_q;
    end
  end

  always_comb begin
    case (mem_wb_q.ctrl.wb_sel)
      hart_pkg::WB_MEM: wb_data = i_dmem_rdata;
      hart_pkg::WB_PC4: wb_data = mem_wb_q.pc + 32'd4;  // link address of jal and jalr
      hart_pkg::WB_IMM: wb_data = mem_wb_q.imm;
      default:          wb_data = mem_wb_q.alu_result;
    endcase
  end

  assign rd_wen   = mem_wb_q.valid && mem_wb_q.ctrl.reg_write;
  assign rd_waddr = rd_wen ? mem_wb_q.inst[11:7] : '0;

  assign o_retire.valid    = mem_wb_q.valid;  // one strobe per instruction, in order
  assign o_retire.inst     = mem_wb_q.inst;
  assign o_retire.halt     = mem_wb_q.ctrl.halt;
  assign o_retire.pc       = mem_wb_q.pc;
  assign o_retire.next_pc  = mem_wb_q.next_pc;
  assign o_retire.rd_waddr = rd_waddr;
  assign o_retire.rd_wdata = wb_data;

endmodule

// File: verification/hart_sva.sv
`timescale 1ns/1ps

module hart_sva (
  input logic              i_clk,
  input logic              i_rst,
  input logic [31:0]       i_dmem_addr,
  input logic              i_dmem_ren,
  input logic              i_dmem_wen,
  input hart_pkg::retire_t i_retire
);

  // the memory stage holds one instruction, so it can never load and store at once
  rw_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_dmem_ren && i_dmem_wen))
    else $error("dmem read and write enabled in the same cycle");

  // only word accesses exist, the address matters only while a port is enabled
  addr_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_dmem_ren || i_dmem_wen) |-> i_dmem_addr[1:0] == 2'b00)
    else $error("dmem address %h is not word aligned", i_dmem_addr);

  retire_quiet_in_reset: assert property (@(posedge i_clk)
    i_rst |=> !i_retire.valid)  // writeback register is cleared by the reset edge
    else $error("retire valid is high right after a reset cycle");

endmodule

// File: verification/hart_tb.sv
`timescale 1ns/1ps

module hart_tb;

  logic              clk = 1'b0;
  logic              rst;
  logic [31:0]       imem_raddr;
  logic [31:0]       imem_rdata;
  logic [31:0]       dmem_addr;
  logic              dmem_ren;
  logic              dmem_wen;
  logic [31:0]       dmem_wdata;
  logic [3:0]        dmem_mask;
  logic [31:0]       dmem_rdata;
  hart_pkg::retire_t retire;
  hart_pkg::retire_t expected;     // what the reference model says should retire next

  logic [31:0] imem [0:63];
  logic [31:0] dmem [0:255];
  logic [31:0] ref_mem [0:255];    // reference copy of dmem, only the model touches it
  logic [31:0] ref_regs [0:31];
  logic [31:0] ref_pc;
  logic        ref_done;           // ebreak has retired in the reference model
  logic [31:0] lfsr_state;
  int          prog_len;
  int          checks;
  int          errors;             // value mismatches
  int          faults;             // retirements that should never have happened

  hart hart_i (.i_clk(clk), .i_rst(rst), .o_imem_raddr(imem_raddr), .i_imem_rdata(imem_rdata),
               .o_dmem_addr(dmem_addr), .o_dmem_ren(dmem_ren), .o_dmem_wen(dmem_wen),
               .o_dmem_wdata(dmem_wdata), .o_dmem_mask(dmem_mask), .i_dmem_rdata(dmem_rdata),
               .o_retire(retire));

  bind hart hart_sva sva_i (.i_clk(i_clk), .i_rst(i_rst), .i_dmem_addr(o_dmem_addr),
                            .i_dmem_ren(o_dmem_ren), .i_dmem_wen(o_dmem_wen),
                            .i_retire(o_retire));

  initial begin
    forever #10 clk = ~clk;
  end

  // both memories answer one clock after the address, like block rams
  always @(posedge clk) begin
    imem_rdata <= imem[imem_raddr[7:2]];
    if (dmem_ren)
      dmem_rdata <= dmem[dmem_addr[9:2]];
    if (dmem_wen)
      dmem[dmem_addr[9:2]] <= dmem_wdata;
  end

  // fibonacci lfsr with taps 32 22 2 1, one step per bit handed out
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, hart_pkg::OP_REG};
  endfunction

  function automatic logic [31:0] itype(input logic [6:0] op, input logic [2:0] f3,
                                        input logic [4:0] rd, rs1, input logic [31:0] imm);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] stype(input logic [4:0] rs2, rs1, input logic [31:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], hart_pkg::OP_STORE};  // sw only
  endfunction

  function automatic logic [31:0] btype(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                        input logic [31:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], hart_pkg::OP_BRANCH};
  endfunction

  function automatic logic [31:0] jtype(input logic [4:0] rd, input logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, hart_pkg::OP_JAL};
  endfunction

  task automatic emit(input logic [31:0] inst);
    imem[prog_len] = inst;
    prog_len++;
  endtask

  task automatic build_program();
    logic [31:0] sh;
    logic [31:0] off;
    logic [31:0] upper;
    // unused words are nops that still carry their own index
    for (int a = 0; a < 64; a++)
      imem[a] = itype(hart_pkg::OP_IMM, 3'b000, 5'd0, 5'd0, a);
    prog_len = 0;
    sh    = lfsr_bits(5);
    off   = lfsr_bits(4) << 2;
    upper = lfsr_bits(20);
    emit({upper[19:0], 5'd1, hart_pkg::OP_LUI});
    emit(itype(hart_pkg::OP_IMM, 3'b000, 1, 1, lfsr_bits(12)));  // needs x1 right away
    emit(itype(hart_pkg::OP_IMM, 3'b000, 2, 0, lfsr_bits(12)));
    emit(rtype(7'h00, 3'b000, 3, 1, 2));
    emit(rtype(7'h20, 3'b000, 4, 1, 2));
    emit(rtype(7'h00, 3'b111, 5, 3, 4));
    emit(rtype(7'h00, 3'b110, 6, 3, 2));
    emit(rtype(7'h00, 3'b100, 7, 6, 1));
    emit(rtype(7'h00, 3'b010, 8, 1, 2));
    emit(rtype(7'h00, 3'b011, 9, 1, 2));
    emit(itype(hart_pkg::OP_IMM, 3'b001, 10, 3, sh));
    emit(itype(hart_pkg::OP_IMM, 3'b101, 11, 1, sh));
    emit(itype(hart_pkg::OP_IMM, 3'b101, 12, 1, 32'h400 | sh));  // srai
    emit(rtype(7'h00, 3'b001, 13, 2, 4));
    emit(rtype(7'h00, 3'b101, 14, 1, 2));
    emit(rtype(7'h20, 3'b101, 15, 1, 2));
    emit(itype(hart_pkg::OP_IMM, 3'b111, 16, 1, lfsr_bits(12)));
    emit(itype(hart_pkg::OP_IMM, 3'b110, 17, 2, lfsr_bits(12)));
    emit(itype(hart_pkg::OP_IMM, 3'b100, 18, 3, lfsr_bits(12)));
    emit(itype(hart_pkg::OP_IMM, 3'b010, 19, 1, lfsr_bits(12)));
    emit(itype(hart_pkg::OP_IMM, 3'b011, 20, 2, lfsr_bits(12)));
    emit(itype(hart_pkg::OP_IMM, 3'b000, 21, 0, 32'h100));       // dmem base
    emit(stype(7, 21, off));
    emit(itype(hart_pkg::OP_LOAD, 3'b010, 22, 21, off));         // reads back the store
    emit(rtype(7'h00, 3'b000, 23, 22, 1));                       // load-use stall
    emit(btype(3'b000, 1, 1, 8));                                // beq taken
    emit(itype(hart_pkg::OP_IMM, 3'b000, 24, 0, 1));
    emit(btype(3'b001, 1, 1, 8));                                // bne not taken
    emit(btype(3'b100, 2, 1, 8));                                // blt and bge disagree
    emit(itype(hart_pkg::OP_IMM, 3'b000, 25, 0, 2));
    emit(btype(3'b101, 2, 1, 8));
    emit(itype(hart_pkg::OP_IMM, 3'b000, 26, 0, 3));
    emit(jtype(27, 8));
    emit(itype(hart_pkg::OP_IMM, 3'b000, 28, 0, 4));
    emit(itype(hart_pkg::OP_IMM, 3'b000, 29, 0, 149));           // odd, jalr drops bit 0
    emit(itype(hart_pkg::OP_JALR, 3'b000, 30, 29, 0));
    emit(itype(hart_pkg::OP_IMM, 3'b000, 31, 0, 5));
    emit(rtype(7'h00, 3'b000, 31, 30, 27));
    emit(hart_pkg::EBREAK_INST);
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt)
          return $signed(a) >>> b[4:0];  // copies of the sign bit shift in
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // runs the instruction at ref_pc on the model state and returns its retire report
  function automatic hart_pkg::retire_t ref_step();
    hart_pkg::retire_t r;
    logic [31:0]       inst;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       imm_i;
    logic [31:0]       ea;
    logic              wr;
    logic              take;
    inst  = imem[ref_pc[7:2]];
    a     = ref_regs[inst[19:15]];
    b     = ref_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    r         = '0;
    r.valid   = 1'b1;
    r.inst    = inst;
    r.pc      = ref_pc;
    r.next_pc = ref_pc + 32'd4;
    r.halt    = inst == hart_pkg::EBREAK_INST;
    wr        = 1'b0;
    take      = 1'b0;
    case (inst[6:0])
      hart_pkg::OP_LUI: begin
        wr          = 1'b1;
        r.rd_wdata  = {inst[31:12], 12'h000};
      end
      hart_pkg::OP_JAL: begin
        wr          = 1'b1;
        r.rd_wdata  = ref_pc + 32'd4;
        r.next_pc   = ref_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      hart_pkg::OP_JALR: begin
        wr          = 1'b1;
        r.rd_wdata  = ref_pc + 32'd4;
        r.next_pc   = (a + imm_i) & ~32'd1;
      end
      hart_pkg::OP_BRANCH: begin
        case (inst[14:12])
          3'b000:  take = a == b;
          3'b001:  take = a != b;
          3'b100:  take = $signed(a) < $signed(b);
          3'b101:  take = $signed(a) >= $signed(b);
          default: take = 1'b0;
        endcase
        if (take)
          r.next_pc = ref_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      hart_pkg::OP_LOAD: begin
        wr          = 1'b1;
        ea          = a + imm_i;
        r.rd_wdata  = ref_mem[ea[9:2]];
      end
      hart_pkg::OP_STORE: begin
        ea = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
        ref_mem[ea[9:2]] = b;
      end
      hart_pkg::OP_IMM: begin
        wr          = 1'b1;  // only srai takes bit 30, addi never subtracts
        r.rd_wdata  = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'b101, a, imm_i);
      end
      hart_pkg::OP_REG: begin
        wr          = 1'b1;
        r.rd_wdata  = alu_ref(inst[14:12], inst[30], a, b);
      end
      default: ;
    endcase
    if (wr && inst[11:7] != 5'd0) begin
      r.rd_waddr = inst[11:7];
      ref_regs[inst[11:7]] = r.rd_wdata;
    end
    ref_pc = r.next_pc;
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAILED %s got %h expected %h", name, got, want);
    end
  endtask

  // retire outputs are sampled in the middle of the cycle where they are settled
  always @(negedge clk) begin
    if (!rst && (dmem_ren === 1'b1 || dmem_wen === 1'b1))
      check_value("dmem_mask", 32'(dmem_mask), 32'h0000_000f);  // word accesses enable all bytes
    if (!rst && retire.valid === 1'b1) begin
      if (retire.pc !== ref_pc) begin
        faults++;  // a squashed or skipped instruction shows up here
        $display("instruction at pc %h retired where the program continues at pc %h",
                 retire.pc, ref_pc);
      end else begin
        expected = ref_step();
        check_value("retire.inst", retire.inst, expected.inst);
        check_value("retire.next_pc", retire.next_pc, expected.next_pc);
        check_value("retire.rd_waddr", 32'(retire.rd_waddr), 32'(expected.rd_waddr));
        if (expected.rd_waddr != '0)
          check_value("retire.rd_wdata", retire.rd_wdata, expected.rd_wdata);
        check_value("retire.halt", 32'(retire.halt), 32'(expected.halt));
        ref_done = expected.halt;
      end
    end
  end

  initial begin
    rst        = 1'b1;
    imem_rdata = '0;
    dmem_rdata = '0;
    ref_done   = 1'b0;
    checks     = 0;
    errors     = 0;
    faults     = 0;
    lfsr_state = 32'h9de1d9e0;
    ref_pc     = hart_pkg::RESET_ADDR;
    for (int a = 0; a < 32; a++)
      ref_regs[a] = '0;
    for (int a = 0; a < 256; a++) begin
      dmem[a]    = 32'hd000_0000 | (a << 2);  // each word holds its own byte address
      ref_mem[a] = 32'hd000_0000 | (a << 2);
    end
    build_program();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    wait (ref_done);
    $display("checks %0d, mismatches %0d, unexpected retirements %0d", checks, errors, faults);
    if (errors == 0 && faults == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // every instruction gets eight cycles, far more than stalls and squashes cost
  initial begin
    @(negedge rst);
    repeat (prog_len * 8) @(posedge clk);
    $display("timeout, ebreak did not retire within %0d cycles", prog_len * 8);
    $display("checks %0d, mismatches %0d, unexpected retirements %0d", checks, errors, faults);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: filelist.f
verilog/hart_pkg.sv
verilog/hart_decode.sv
verilog/hart_regfile.sv
verilog/hart_execute.sv
verilog/hart_hazard.sv
verilog/hart.sv
verification/hart_sva.sv
verification/hart_tb.sv

// File: Bender.yml
package:
  name: hart

sources:
  - verilog/hart_pkg.sv
  - verilog/hart_decode.sv
  - verilog/hart_regfile.sv
  - verilog/hart_execute.sv
  - verilog/hart_hazard.sv
  - verilog/hart.sv
  - target: test
    files:
      - verification/hart_sva.sv
      - verification/hart_tb.sv
